// File: kl_backplane.f
src/kl_word_pkg.sv
src/kl_bus_pkg.sv
src/kl_phase_clock.sv
src/kl_diag_register.sv
src/kl_edp_slice.sv
src/kl_ebus_mux.sv
src/kl_front_end.sv
src/kl_mbus_memory.sv
src/kl_backplane.sv
bench/kl_backplane_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the backplane testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module kl_backplane_tb \
  -f kl_backplane.f \
  -o kl_backplane_sim

./obj_dir/kl_backplane_sim

// File: bench/kl_backplane_tb.sv
`timescale 1ns/1ns

module kl_backplane_tb;

  localparam int MEM_WORDS = 512;
  localparam int RESET_CYCLES = 5;
  localparam int CYCLES_PER_ROW = 40;
  localparam int RANDOM_WRITES = 6;
  localparam int SEED = 32'h58ab_69fb;

  logic top_clk;
  logic rst;
  logic cmd_valid;
  logic cmd_ready;
  kl_bus_pkg::fe_op_t cmd_op;
  kl_bus_pkg::ebus_cs_t cmd_cs;
  kl_bus_pkg::ebus_ds_t cmd_ds;
  kl_word_pkg::mem_addr_t cmd_addr;
  kl_word_pkg::word_t cmd_data;
  logic rsp_valid;
  logic rsp_ready;
  kl_word_pkg::word_t rsp_data;

  // Stimulus table, one entry per command, with the response it must give
  kl_bus_pkg::fe_op_t row_op [$];
  kl_bus_pkg::ebus_cs_t row_cs [$];
  kl_bus_pkg::ebus_ds_t row_ds [$];
  kl_word_pkg::mem_addr_t row_addr [$];
  kl_word_pkg::word_t row_data [$];
  kl_word_pkg::word_t row_exp [$];

  // Reference copy of the memory for the random rows
  kl_word_pkg::word_t mem_model [1024];
  kl_word_pkg::mem_addr_t rand_addrs [$];

  int cycles;
  int timeout_cycles;
  int responses;
  int seed_result;
  logic [31:0] ready_roll;

  kl_backplane #(.MEM_WORDS(MEM_WORDS)) i_kl_backplane (
    .top_clk, .rst,
    .cmd_valid, .cmd_ready, .cmd_op, .cmd_cs, .cmd_ds, .cmd_addr, .cmd_data,
    .rsp_valid, .rsp_ready, .rsp_data
  );

  always #50 top_clk = ~top_clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input string name, input int row,
                            input kl_word_pkg::word_t expected,
                            input kl_word_pkg::word_t actual);
    string line;
    if (actual !== expected) begin
      line = $sformatf("MISMATCH %s row %0d expected %h actual %h",
                       name, row, expected, actual);
      report_failure(line);
    end
  endtask

  task automatic add_row(input kl_bus_pkg::fe_op_t op, input kl_bus_pkg::ebus_cs_t cs,
                         input kl_bus_pkg::ebus_ds_t ds, input kl_word_pkg::mem_addr_t addr,
                         input kl_word_pkg::word_t data, input kl_word_pkg::word_t expected);
    row_op.push_back(op);
    row_cs.push_back(cs);
    row_ds.push_back(ds);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_exp.push_back(expected);
  endtask

  task automatic add_diag(input kl_bus_pkg::ebus_cs_t cs, input kl_bus_pkg::ebus_ds_t ds,
                          input kl_word_pkg::word_t data, input kl_word_pkg::word_t expected);
    add_row(kl_bus_pkg::OP_DIAG, cs, ds, '0, data, expected);
  endtask

  task automatic build_directed_rows();
    // Two register boards hold their own values
    add_diag(kl_bus_pkg::CS_APR, kl_bus_pkg::DS_WRITE, 36'o123456701234, 36'o123456701234);
    add_diag(kl_bus_pkg::CS_CON, kl_bus_pkg::DS_WRITE, 36'o765432107654, 36'o765432107654);
    add_diag(kl_bus_pkg::CS_APR, kl_bus_pkg::DS_READ, '0, 36'o123456701234);
    add_diag(kl_bus_pkg::CS_CON, kl_bus_pkg::DS_READ, '0, 36'o765432107654);
    // Every slice lands at its own bit position on the way back
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_WRITE, 36'o112233445566, 36'o112233445566);
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_READ, '0, 36'o112233445566);
    // Increments that carry across one slice, across three, and off the top
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_WRITE, 36'o000000000077, 36'o000000000077);
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_INCR, '0, 36'o000000000100);
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_WRITE, 36'o000000777777, 36'o000000777777);
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_INCR, '0, 36'o000001000000);
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_READ, '0, 36'o000001000000);
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_WRITE, 36'o777777777777, 36'o777777777777);
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_INCR, '0, 36'o000000000000);
    add_diag(kl_bus_pkg::CS_EDP, kl_bus_pkg::DS_READ, '0, 36'o000000000000);
    // Nobody answers this select
    add_diag(7'h3f, kl_bus_pkg::DS_READ, '0, 36'o000000000000);
    // The register boards kept their values through the datapath traffic
    add_diag(kl_bus_pkg::CS_APR, kl_bus_pkg::DS_READ, '0, 36'o123456701234);
    add_row(kl_bus_pkg::OP_MEM_WRITE, '0, '0, 10'h005, 36'o101010101010, 36'o101010101010);
    add_row(kl_bus_pkg::OP_MEM_WRITE, '0, '0, 10'h1ff, 36'o707070707070, 36'o707070707070);
    add_row(kl_bus_pkg::OP_MEM_WRITE, '0, '0, 10'h100, 36'o543210123456, 36'o543210123456);
    add_row(kl_bus_pkg::OP_MEM_READ, '0, '0, 10'h100, '0, 36'o543210123456);
    add_row(kl_bus_pkg::OP_MEM_READ, '0, '0, 10'h005, '0, 36'o101010101010);
    add_row(kl_bus_pkg::OP_MEM_READ, '0, '0, 10'h1ff, '0, 36'o707070707070);
  endtask

  task automatic build_random_rows();
    logic [63:0] r64;
    logic [31:0] a32;
    kl_word_pkg::mem_addr_t addr;
    kl_word_pkg::word_t data;
    for (int k = 0; k < RANDOM_WRITES; k++) begin
      a32 = $urandom % MEM_WORDS;
      r64 = {$urandom, $urandom};
      addr = a32[9:0];
      data = r64[35:0];
      mem_model[addr] = data;
      rand_addrs.push_back(addr);
      add_row(kl_bus_pkg::OP_MEM_WRITE, '0, '0, addr, data, data);
    end
    // Read back newest first, a repeated address gives its last write
    for (int k = RANDOM_WRITES - 1; k >= 0; k--) begin
      add_row(kl_bus_pkg::OP_MEM_READ, '0, '0, rand_addrs[k], '0, mem_model[rand_addrs[k]]);
    end
  endtask

  task automatic apply_row(input int i);
    @(posedge top_clk);
    cmd_valid <= 1'b1;
    cmd_op <= row_op[i];
    cmd_cs <= row_cs[i];
    cmd_ds <= row_ds[i];
    cmd_addr <= row_addr[i];
    cmd_data <= row_data[i];
    @(negedge top_clk);
    while (!cmd_ready) begin
      @(negedge top_clk);
    end
    // The command is taken at this edge
    @(posedge top_clk);
    cmd_valid <= 1'b0;
    @(negedge top_clk);
    while (!(rsp_valid && rsp_ready)) begin
      if (rsp_valid && cmd_ready) begin
        report_failure("cmd_ready went high while a response was still waiting");
      end
      @(negedge top_clk);
    end
    check_word("rsp_data", i, row_exp[i], rsp_data);
  endtask

  // Random back-pressure on the response channel
  always @(posedge top_clk) begin
    ready_roll = $urandom;
    rsp_ready <= ready_roll[0];
  end

  // Every handshake on the response channel is counted, whichever row is running
  always @(posedge top_clk) begin
    if (rsp_valid && rsp_ready) begin
      responses <= responses + 1;
    end
  end

  always @(posedge top_clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      report_failure("timeout waiting for response");
    end
  end

  initial begin
    top_clk = 1'b0;
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = kl_bus_pkg::OP_DIAG;
    cmd_cs = '0;
    cmd_ds = '0;
    cmd_addr = '0;
    cmd_data = '0;
    rsp_ready = 1'b0;
    cycles = 0;
    responses = 0;
    seed_result = $urandom(SEED);
    build_directed_rows();
    build_random_rows();
    timeout_cycles = row_op.size() * CYCLES_PER_ROW + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge top_clk);
    rst <= 1'b0;

    for (int i = 0; i < row_op.size(); i++) begin
      apply_row(i);
    end

    // The last handshake edge has to settle before the count is read
    @(posedge top_clk);
    @(negedge top_clk);
    if (responses == row_op.size()) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      report_failure("the number of responses differs from the number of commands");
    end
  end

endmodule

// File: src/kl_backplane.sv
`timescale 1ns/1ns

module kl_backplane #(
  parameter int MEM_WORDS = 512
) (
  input  logic                   top_clk,
  input  logic                   rst,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  kl_bus_pkg::fe_op_t     cmd_op,
  input  kl_bus_pkg::ebus_cs_t   cmd_cs,
  input  kl_bus_pkg::ebus_ds_t   cmd_ds,
  input  kl_word_pkg::mem_addr_t cmd_addr,
  input  kl_word_pkg::word_t     cmd_data,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output kl_word_pkg::word_t     rsp_data
);

  logic [3:0] ph;
  kl_bus_pkg::ebus_cs_t ebus_cs;
  kl_bus_pkg::ebus_ds_t ebus_ds;
  logic ebus_strobe;
  kl_word_pkg::word_t ebus_data;
  kl_word_pkg::word_t fe_ebus_data;
  kl_word_pkg::word_t mux_data;
  logic apr_driving;
  logic con_driving;
  kl_word_pkg::word_t apr_data;
  kl_word_pkg::word_t con_data;
  logic edp_driving [kl_word_pkg::SLICE_COUNT];
  kl_word_pkg::slice_t edp_data [kl_word_pkg::SLICE_COUNT];
  logic [kl_word_pkg::SLICE_COUNT:0] edp_carry;
  logic mem_start;
  logic mem_write;
  kl_word_pkg::mem_addr_t mem_addr;
  kl_word_pkg::word_t mem_wdata;
  logic mem_ack;
  logic mem_rdata_valid;
  kl_word_pkg::word_t mem_rdata;

  kl_phase_clock i_kl_phase_clock (.top_clk, .rst, .ph, .clk_master());

  kl_front_end i_kl_front_end (
    .top_clk, .rst, .ph,
    .cmd_valid, .cmd_ready, .cmd_op, .cmd_cs, .cmd_ds, .cmd_addr, .cmd_data,
    .rsp_valid, .rsp_ready, .rsp_data,
    .ebus_cs, .ebus_ds, .ebus_strobe, .ebus_data_out(fe_ebus_data), .ebus_data,
    .mem_start, .mem_write, .mem_addr, .mem_wdata,
    .mem_ack, .mem_rdata_valid, .mem_rdata
  );

  // The front end owns the data lines for the whole of a write cycle
  assign ebus_data = (ebus_ds == kl_bus_pkg::DS_WRITE) ? fe_ebus_data : mux_data;

  kl_diag_register #(.DEV_CS(kl_bus_pkg::CS_APR)) i_apr (
    .top_clk, .rst, .ebus_cs, .ebus_ds, .ebus_strobe, .ebus_data,
    .driving(apr_driving), .data(apr_data)
  );

  kl_diag_register #(.DEV_CS(kl_bus_pkg::CS_CON)) i_con (
    .top_clk, .rst, .ebus_cs, .ebus_ds, .ebus_strobe, .ebus_data,
    .driving(con_driving), .data(con_data)
  );

  // The increment always adds one at the bottom slice
  assign edp_carry[0] = 1'b1;

  for (genvar n = 0; n < kl_word_pkg::SLICE_COUNT; n++) begin : g_edp
    kl_edp_slice #(.SLICE(n)) i_edp (
      .top_clk, .rst, .ebus_cs, .ebus_ds, .ebus_strobe, .ebus_data,
      .carry_in(edp_carry[n]), .carry_out(edp_carry[n+1]),
      .driving(edp_driving[n]), .data(edp_data[n])
    );
  end

  kl_ebus_mux i_kl_ebus_mux (
    .apr_driving, .apr_data, .con_driving, .con_data,
    .edp_driving_0(edp_driving[0]), .edp_driving_1(edp_driving[1]),
    .edp_driving_2(edp_driving[2]), .edp_driving_3(edp_driving[3]),
    .edp_driving_4(edp_driving[4]), .edp_driving_5(edp_driving[5]),
    .edp_data_0(edp_data[0]), .edp_data_1(edp_data[1]), .edp_data_2(edp_data[2]),
    .edp_data_3(edp_data[3]), .edp_data_4(edp_data[4]), .edp_data_5(edp_data[5]),
    .ebus_data(mux_data)
  );

  kl_mbus_memory #(.MEM_WORDS(MEM_WORDS)) i_kl_mbus_memory (
    .top_clk, .rst, .mem_start, .mem_write, .mem_addr, .mem_wdata,
    .mem_ack, .mem_rdata_valid, .mem_rdata
  );

endmodule

// File: src/kl_mbus_memory.sv
`timescale 1ns/1ns

module kl_mbus_memory #(
  parameter int MEM_WORDS = 512
) (
  input  logic                   top_clk,
  input  logic                   rst,
  input  logic                   mem_start,
  input  logic                   mem_write,
  input  kl_word_pkg::mem_addr_t mem_addr,
  input  kl_word_pkg::word_t     mem_wdata,
  output logic                   mem_ack,
  output logic                   mem_rdata_valid,
  output kl_word_pkg::word_t     mem_rdata
);

  localparam int INDEX_BITS = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  // Acknowledge, then a gap cycle for the array read, then data valid
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_ACK,
    MEM_GAP,
    MEM_VALID
  } mem_state_t;

  mem_state_t state;
  kl_word_pkg::word_t mem [MEM_WORDS];
  logic [INDEX_BITS-1:0] index;
  logic [INDEX_BITS-1:0] index_q;
  logic write_q;
  logic take;

  // Addresses above the depth wrap around
  assign index = mem_addr[INDEX_BITS-1:0];
  assign take = (state == MEM_IDLE) && mem_start;

  assign mem_ack = state == MEM_ACK;
  assign mem_rdata_valid = state == MEM_VALID;

  always_ff @(posedge top_clk) begin
    if (rst) begin
      state <= MEM_IDLE;
    end else begin
      case (state)
        MEM_IDLE: if (mem_start) state <= MEM_ACK;
        MEM_ACK: state <= write_q ? MEM_IDLE : MEM_GAP;
        MEM_GAP: state <= MEM_VALID;
        default: state <= MEM_IDLE;
      endcase
    end
  end

  // A write goes into the array in the same cycle that the start is seen
  always_ff @(posedge top_clk) begin
    if (take) begin
      write_q <= mem_write;
      index_q <= index;
      if (mem_write) begin
        mem[index] <= mem_wdata;
      end
    end
    if (state == MEM_GAP) begin
      mem_rdata <= mem[index_q];
    end
  end

endmodule

// File: src/kl_front_end.sv
`timescale 1ns/1ns

module kl_front_end (
  input  logic                   top_clk,
  input  logic                   rst,
  input  logic [3:0]             ph,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  kl_bus_pkg::fe_op_t     cmd_op,
  input  kl_bus_pkg::ebus_cs_t   cmd_cs,
  input  kl_bus_pkg::ebus_ds_t   cmd_ds,
  input  kl_word_pkg::mem_addr_t cmd_addr,
  input  kl_word_pkg::word_t     cmd_data,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output kl_word_pkg::word_t     rsp_data,
  output kl_bus_pkg::ebus_cs_t   ebus_cs,
  output kl_bus_pkg::ebus_ds_t   ebus_ds,
  output logic                   ebus_strobe,
  output kl_word_pkg::word_t     ebus_data_out,
  input  kl_word_pkg::word_t     ebus_data,
  output logic                   mem_start,
  output logic                   mem_write,
  output kl_word_pkg::mem_addr_t mem_addr,
  output kl_word_pkg::word_t     mem_wdata,
  input  logic                   mem_ack,
  input  logic                   mem_rdata_valid,
  input  kl_word_pkg::word_t     mem_rdata
);

  kl_bus_pkg::fe_state_t state;
  kl_bus_pkg::fe_op_t op_q;
  kl_bus_pkg::ebus_cs_t cs_q;
  kl_bus_pkg::ebus_ds_t ds_q;
  kl_word_pkg::mem_addr_t addr_q;
  kl_word_pkg::word_t data_q;
  logic accept;
  logic in_ebus;

  // Only one command is in flight, so the channel is ready only when idle
  assign cmd_ready = state == kl_bus_pkg::ST_IDLE;
  assign accept = cmd_valid && cmd_ready;
  assign rsp_valid = state == kl_bus_pkg::ST_RESP;

  assign in_ebus = state inside {kl_bus_pkg::ST_EBUS_SETUP, kl_bus_pkg::ST_EBUS_STROBE,
                                 kl_bus_pkg::ST_EBUS_SAMPLE};
  assign ebus_strobe = state == kl_bus_pkg::ST_EBUS_STROBE;

  always_comb begin
    ebus_cs = '0;
    ebus_ds = '0;
    if (in_ebus) begin
      ebus_cs = cs_q;
      ebus_ds = ds_q;
      // After the increment has loaded, the slices are read back in phase 4
      if (state == kl_bus_pkg::ST_EBUS_SAMPLE && ds_q == kl_bus_pkg::DS_INCR) begin
        ebus_ds = kl_bus_pkg::DS_READ;
      end
    end
  end

  assign ebus_data_out = (in_ebus && ds_q == kl_bus_pkg::DS_WRITE) ? data_q : '0;

  assign mem_start = state == kl_bus_pkg::ST_MEM_START;
  assign mem_write = op_q == kl_bus_pkg::OP_MEM_WRITE;
  assign mem_addr = addr_q;
  assign mem_wdata = data_q;

  always_ff @(posedge top_clk) begin
    if (rst) begin
      state <= kl_bus_pkg::ST_IDLE;
      op_q <= kl_bus_pkg::OP_DIAG;
    end else begin
      case (state)
        kl_bus_pkg::ST_IDLE: begin
          if (accept) begin
            op_q <= cmd_op;
            if (cmd_op == kl_bus_pkg::OP_DIAG) begin
              state <= kl_bus_pkg::ST_EBUS_SETUP;
            end else begin
              state <= kl_bus_pkg::ST_MEM_START;
            end
          end
        end
        // Hold select and function until the phase-2 cycle, so the strobe lands in phase 3
        kl_bus_pkg::ST_EBUS_SETUP: if (ph[1]) state <= kl_bus_pkg::ST_EBUS_STROBE;
        kl_bus_pkg::ST_EBUS_STROBE: state <= kl_bus_pkg::ST_EBUS_SAMPLE;
        kl_bus_pkg::ST_EBUS_SAMPLE: state <= kl_bus_pkg::ST_RESP;
        kl_bus_pkg::ST_MEM_START: begin
          if (mem_ack) begin
            state <= mem_write ? kl_bus_pkg::ST_RESP : kl_bus_pkg::ST_MEM_WAIT;
          end
        end
        kl_bus_pkg::ST_MEM_WAIT: if (mem_rdata_valid) state <= kl_bus_pkg::ST_RESP;
        kl_bus_pkg::ST_RESP: if (rsp_ready) state <= kl_bus_pkg::ST_IDLE;
        default: state <= kl_bus_pkg::ST_IDLE;
      endcase
    end
  end

  // Command fields and the response word
  always_ff @(posedge top_clk) begin
    if (accept) begin
      cs_q <= cmd_cs;
      ds_q <= cmd_ds;
      addr_q <= cmd_addr;
      data_q <= cmd_data;
    end
    if (state == kl_bus_pkg::ST_EBUS_SAMPLE) begin
      rsp_data <= ebus_data;
    end else if (state == kl_bus_pkg::ST_MEM_START && mem_ack && mem_write) begin
      rsp_data <= data_q;
    end else if (state == kl_bus_pkg::ST_MEM_WAIT && mem_rdata_valid) begin
      rsp_data <= mem_rdata;
    end
  end

endmodule

// File: src/kl_ebus_mux.sv
`timescale 1ns/1ns

module kl_ebus_mux (
  input  logic                apr_driving,
  input  kl_word_pkg::word_t  apr_data,
  input  logic                con_driving,
  input  kl_word_pkg::word_t  con_data,
  input  logic                edp_driving_0,
  input  logic                edp_driving_1,
  input  logic                edp_driving_2,
  input  logic                edp_driving_3,
  input  logic                edp_driving_4,
  input  logic                edp_driving_5,
  input  kl_word_pkg::slice_t edp_data_0,
  input  kl_word_pkg::slice_t edp_data_1,
  input  kl_word_pkg::slice_t edp_data_2,
  input  kl_word_pkg::slice_t edp_data_3,
  input  kl_word_pkg::slice_t edp_data_4,
  input  kl_word_pkg::slice_t edp_data_5,
  output kl_word_pkg::word_t  ebus_data
);

  logic edp_driving;
  kl_word_pkg::word_t edp_word;

  // The six EDP boards answer together for one select
  assign edp_driving = edp_driving_0 | edp_driving_1 | edp_driving_2 |
                       edp_driving_3 | edp_driving_4 | edp_driving_5;

  // Slice 5 carries the top of the word and slice 0 the bottom
  assign edp_word = {edp_data_5, edp_data_4, edp_data_3,
                     edp_data_2, edp_data_1, edp_data_0};

  // APR wins over CON, and CON over the datapath
  always_comb begin
    if (apr_driving) begin
      ebus_data = apr_data;
    end else if (con_driving) begin
      ebus_data = con_data;
    end else if (edp_driving) begin
      ebus_data = edp_word;
    end else begin
      ebus_data = '0;
    end
  end

endmodule

// File: src/kl_edp_slice.sv
`timescale 1ns/1ns

module kl_edp_slice #(
  parameter int SLICE = 0
) (
  input  logic                 top_clk,
  input  logic                 rst,
  input  kl_bus_pkg::ebus_cs_t ebus_cs,
  input  kl_bus_pkg::ebus_ds_t ebus_ds,
  input  logic                 ebus_strobe,
  input  kl_word_pkg::word_t   ebus_data,
  input  logic                 carry_in,
  output logic                 carry_out,
  output logic                 driving,
  output kl_word_pkg::slice_t  data
);

  localparam int LSB = SLICE * kl_word_pkg::SLICE_BITS;

  kl_word_pkg::slice_t slice_q;
  logic [kl_word_pkg::SLICE_BITS:0] sum;
  logic selected;
  logic strobed;

  assign selected = ebus_cs == kl_bus_pkg::CS_EDP;
  assign strobed = ebus_strobe && selected;

  // Ripple adder for this slice, the carry goes on to the next slice up
  assign sum = {1'b0, slice_q} + {{kl_word_pkg::SLICE_BITS{1'b0}}, carry_in};
  assign carry_out = sum[kl_word_pkg::SLICE_BITS];

  always_ff @(posedge top_clk) begin
    if (rst) begin
      slice_q <= '0;
    end else if (strobed && (ebus_ds == kl_bus_pkg::DS_WRITE)) begin
      slice_q <= ebus_data[LSB +: kl_word_pkg::SLICE_BITS];
    end else if (strobed && (ebus_ds == kl_bus_pkg::DS_INCR)) begin
      slice_q <= sum[kl_word_pkg::SLICE_BITS-1:0];
    end
  end

  always_comb begin
    driving = selected && (ebus_ds == kl_bus_pkg::DS_READ);
    if (driving) begin
      data = slice_q;
    end else begin
      data = '0;
    end
  end

endmodule

// File: src/kl_diag_register.sv
`timescale 1ns/1ns

module kl_diag_register #(
  parameter kl_bus_pkg::ebus_cs_t DEV_CS = kl_bus_pkg::CS_APR
) (
  input  logic                 top_clk,
  input  logic                 rst,
  input  kl_bus_pkg::ebus_cs_t ebus_cs,
  input  kl_bus_pkg::ebus_ds_t ebus_ds,
  input  logic                 ebus_strobe,
  input  kl_word_pkg::word_t   ebus_data,
  output logic                 driving,
  output kl_word_pkg::word_t   data
);

  kl_word_pkg::word_t reg_q;
  logic selected;
  logic load;

  assign selected = ebus_cs == DEV_CS;

  // A diagnostic write is taken from the bus in the strobe cycle
  assign load = ebus_strobe && selected && (ebus_ds == kl_bus_pkg::DS_WRITE);

  always_ff @(posedge top_clk) begin
    if (rst) begin
      reg_q <= '0;
    end else if (load) begin
      reg_q <= ebus_data;
    end
  end

  // The board only puts its register on the bus for a read of its own select
  always_comb begin
    driving = selected && (ebus_ds == kl_bus_pkg::DS_READ);
    if (driving) begin
      data = reg_q;
    end else begin
      data = '0;
    end
  end

endmodule

// File: src/kl_phase_clock.sv
`timescale 1ns/1ns

module kl_phase_clock (
  input  logic       top_clk,
  input  logic       rst,
  output logic [3:0] ph,
  output logic       clk_master
);

  // One-hot phase register, bit 0 is phase 1 and bit 3 is phase 4
  always_ff @(posedge top_clk) begin
    if (rst) begin
      ph <= 4'b0001;
    end else begin
      ph <= {ph[2:0], ph[3]};
    end
  end

  // The master clock is high for the first half of the four phases
  assign clk_master = ph[0] | ph[1];

endmodule

// File: src/kl_bus_pkg.sv
package kl_bus_pkg;

  localparam int CS_BITS = 7;
  localparam int DS_BITS = 7;

  // Controller select that picks one board on the EBUS
  typedef logic [CS_BITS-1:0] ebus_cs_t;

  // Diagnostic function that the selected board carries out
  typedef logic [DS_BITS-1:0] ebus_ds_t;

  // Select codes follow the backplane slot numbers of the boards
  // A select of zero is never answered, so the idle bus stays quiet
  localparam ebus_cs_t CS_APR = 7'h34;
  localparam ebus_cs_t CS_CON = 7'h35;
  localparam ebus_cs_t CS_EDP = 7'h39;

  // Function codes, with zero kept free as the idle function
  localparam ebus_ds_t DS_READ = 7'h10;
  localparam ebus_ds_t DS_WRITE = 7'h20;
  // Only the datapath slices act on an increment
  localparam ebus_ds_t DS_INCR = 7'h21;

  // What a command asks the front end to do
  typedef enum logic [1:0] {
    OP_DIAG = 2'd0,
    OP_MEM_READ = 2'd1,
    OP_MEM_WRITE = 2'd2
  } fe_op_t;

  // Front-end sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EBUS_SETUP,
    ST_EBUS_STROBE,
    ST_EBUS_SAMPLE,
    ST_MEM_START,
    ST_MEM_WAIT,
    ST_RESP
  } fe_state_t;

endpackage

// File: src/kl_word_pkg.sv
package kl_word_pkg;

  // A KL10 word is 36 bits wide and the datapath cuts it into 6-bit slices
  localparam int WORD_BITS = 36;
  localparam int SLICE_BITS = 6;
  localparam int SLICE_COUNT = WORD_BITS / SLICE_BITS;

  // Word addresses into the MBUS memory
  localparam int ADDR_BITS = 10;

  // One full machine word as it travels on the EBUS and the MBUS
  typedef logic [WORD_BITS-1:0] word_t;

  // The part of the word that one EDP board holds
  typedef logic [SLICE_BITS-1:0] slice_t;

  // Address of one word in the memory, which holds at most 1024 words
  typedef logic [ADDR_BITS-1:0] mem_addr_t;

endpackage
